// File: adcfifo_pkg.sv
/* shared widths, burst response code and the memory word union
   used by the packer, writer, reader and memory */
package adcfifo_pkg;

  // ********************
  // widths

  // one memory word holds four adc samples
  localparam int DATA_WIDTH = 64;
  localparam int SAMPLE_WIDTH = 16;
  localparam int SAMPLES_PER_WORD = DATA_WIDTH / SAMPLE_WIDTH;

  // ********************
  // burst response

  // okay response, the only code the burst memory returns
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // ********************
  // memory word

  // raw is the bus view for writer, reader and memory
  // lane is the sample view, lane 0 in the low bits holds the oldest sample
  typedef union packed {
    logic [DATA_WIDTH-1:0] raw;
    logic [SAMPLES_PER_WORD-1:0][SAMPLE_WIDTH-1:0] lane;
  } axi_word_t;

endpackage

// File: adcfifo_ctrl.sv
/* capture and readback sequencer with request edge detect and the
   idle, capture, full and readback state machine */
`timescale 1ns/1ps

module adcfifo_ctrl #(
  parameter int MEM_WORDS = 64,
  localparam int CNT_W = $clog2(MEM_WORDS + 1)
) (
  input  logic             axi_clk,
  input  logic             axi_resetn,
  input  logic             capture_req,
  input  logic             dma_xfer_req,
  input  logic [CNT_W-1:0] wr_words,
  input  logic             rd_done,
  output logic             capture_en,
  output logic             capture_done,
  output logic             xfer_init,
  output logic             xfer_enable,
  output logic             flush_credits
);

  // bit 1 of the state set means the memory holds a full capture
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_CAPTURE = 2'd1;
  localparam logic [1:0] ST_FULL = 2'd2;
  localparam logic [1:0] ST_READBACK = 2'd3;

  logic [1:0] state;
  logic       capture_req_d;
  logic       xfer_req_d;
  logic       capture_rise;
  logic       xfer_rise;

  // both requests are levels and only the rising edge acts
  assign capture_rise = capture_req & ~capture_req_d;
  assign xfer_rise = dma_xfer_req & ~xfer_req_d;

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      state <= ST_IDLE;
      capture_req_d <= 1'b0;
      xfer_req_d <= 1'b0;
      xfer_init <= 1'b0;
      flush_credits <= 1'b0;
    end else begin
      capture_req_d <= capture_req;
      xfer_req_d <= dma_xfer_req;
      xfer_init <= 1'b0;
      flush_credits <= 1'b0;
      // a new capture wins from any state and drops old credits
      if (capture_rise) begin
        state <= ST_CAPTURE;
        xfer_init <= 1'b1;
        flush_credits <= 1'b1;
      end else begin
        case (state)
          // counters from the last run are still stale during xfer_init
          ST_CAPTURE: begin
            if (!xfer_init && (wr_words == CNT_W'(MEM_WORDS))) begin
              state <= ST_FULL;
            end
          end
          ST_FULL: begin
            if (xfer_rise) begin
              state <= ST_READBACK;
              xfer_init <= 1'b1;
            end
          end
          // back to full so the same capture can be read again
          ST_READBACK: begin
            if (!xfer_init && rd_done) begin
              state <= ST_FULL;
            end
          end
          default: begin
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

  assign capture_en = (state == ST_CAPTURE);
  assign capture_done = state[1];
  assign xfer_enable = (state == ST_READBACK);

  // writer never commits more words than the memory holds
  a_words_bound: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    wr_words <= CNT_W'(MEM_WORDS));

endmodule

// File: adcfifo_credit.sv
/* dma credit counter: one word per credit pulse, a burst per take */
`timescale 1ns/1ps

module adcfifo_credit #(
  parameter int BURST_LEN = 4,
  parameter int CREDIT_MAX = 16
) (
  input  logic axi_clk,
  input  logic axi_resetn,
  input  logic dma_credit,
  input  logic burst_take,
  input  logic flush_credits,
  output logic credit_ok
);

  localparam int CW = $clog2(CREDIT_MAX + 1);

  logic [CW-1:0] count;
  // one extra bit so the add cannot wrap before saturation
  logic [CW:0]   count_nxt;

  // add the pulse and remove a burst in the same cycle, then clamp
  always_comb begin
    count_nxt = {1'b0, count} + (CW + 1)'(dma_credit);
    if (burst_take) begin
      count_nxt = count_nxt - (CW + 1)'(BURST_LEN);
    end
    if (count_nxt > (CW + 1)'(CREDIT_MAX)) begin
      count_nxt = (CW + 1)'(CREDIT_MAX);
    end
  end

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      count <= '0;
    end else if (flush_credits) begin
      count <= '0;
    end else begin
      count <= count_nxt[CW-1:0];
    end
  end

  // a full burst of room is needed before a read burst goes out
  assign credit_ok = (count >= CW'(BURST_LEN));

  // reader only takes a burst it is entitled to, so no underflow
  a_take_covered: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    burst_take |-> credit_ok);

endmodule

// File: adcfifo_pack.sv
/* sample packer: four adc samples into one memory word */
`timescale 1ns/1ps

module adcfifo_pack (
  input  logic                                   axi_clk,
  input  logic                                   axi_resetn,
  input  logic                                   capture_en,
  input  logic                                   adc_valid,
  input  logic [adcfifo_pkg::SAMPLE_WIDTH-1:0]   adc_data,
  output logic                                   word_valid,
  output adcfifo_pkg::axi_word_t                 word_data
);

  localparam int LW = $clog2(adcfifo_pkg::SAMPLES_PER_WORD);
  localparam logic [LW-1:0] LAST_LANE = LW'(adcfifo_pkg::SAMPLES_PER_WORD - 1);

  logic [LW-1:0]          lane_cnt;
  logic                   take;
  adcfifo_pkg::axi_word_t acc;
  adcfifo_pkg::axi_word_t acc_nxt;

  assign take = capture_en & adc_valid;

  // current sample dropped into its lane, older lanes kept
  always_comb begin
    acc_nxt = acc;
    acc_nxt.lane[lane_cnt] = adc_data;
  end

  // ********************
  // lane counter

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      lane_cnt <= '0;
      word_valid <= 1'b0;
    end else begin
      // partial word at the end of a capture is dropped here
      if (!capture_en) begin
        lane_cnt <= '0;
      end else if (adc_valid) begin
        lane_cnt <= lane_cnt + 1'b1;
      end
      word_valid <= take && (lane_cnt == LAST_LANE);
    end
  end

  // ********************
  // word assembly

  always_ff @(posedge axi_clk) begin
    if (take) begin
      acc <= acc_nxt;
      // whole word handed on in the cycle after the last lane
      if (lane_cnt == LAST_LANE) begin
        word_data.raw <= acc_nxt.raw;
      end
    end
  end

endmodule

// File: adcfifo_wr.sv
/* burst writer with staging buffer, write address and data channel, commit count */
`timescale 1ns/1ps

module adcfifo_wr #(
  parameter int BURST_LEN = 4,
  parameter int MEM_WORDS = 64,
  localparam int AW = $clog2(MEM_WORDS),
  localparam int CNT_W = $clog2(MEM_WORDS + 1)
) (
  input  logic                                 axi_clk,
  input  logic                                 axi_resetn,
  input  logic                                 capture_en,
  input  logic                                 xfer_init,
  input  logic                                 word_valid,
  input  adcfifo_pkg::axi_word_t               word_data,
  input  logic                                 awready,
  input  logic                                 wready,
  input  logic                                 bvalid,
  input  logic [1:0]                           bresp,
  output logic                                 awvalid,
  output logic [AW-1:0]                        awaddr,
  output logic                                 wvalid,
  output logic [adcfifo_pkg::DATA_WIDTH-1:0]   wdata,
  output logic                                 wlast,
  output logic [CNT_W-1:0]                     wr_words
);

  localparam int BW = $clog2(BURST_LEN);
  localparam logic [BW-1:0] LAST_BEAT = BW'(BURST_LEN - 1);

  // one burst worth of words
  // slot k goes out well before the next burst's word k lands
  logic [adcfifo_pkg::DATA_WIDTH-1:0] stage [BURST_LEN];
  logic [BW-1:0]    fill;
  logic [BW-1:0]    beat;
  logic [CNT_W-1:0] words_in;
  logic             accept;

  // words past the memory depth are ignored
  assign accept = capture_en && word_valid && (words_in != CNT_W'(MEM_WORDS));
  assign wdata = stage[beat];
  assign wlast = wvalid && (beat == LAST_BEAT);

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      fill <= '0;
      beat <= '0;
      words_in <= '0;
      awaddr <= '0;
      wr_words <= '0;
      awvalid <= 1'b0;
      wvalid <= 1'b0;
    end else begin
      if (xfer_init) begin
        fill <= '0;
        words_in <= '0;
        awaddr <= '0;
        wr_words <= '0;
      end else begin
        if (accept) begin
          fill <= (fill == LAST_BEAT) ? '0 : fill + 1'b1;
          words_in <= words_in + 1'b1;
        end
        if (awvalid && awready) begin
          awaddr <= awaddr + AW'(BURST_LEN);
        end
        // only words the memory has acknowledged count as stored
        if (bvalid) begin
          wr_words <= wr_words + CNT_W'(BURST_LEN);
        end
      end
      // ********************
      // address then data phase
      if (awvalid && awready) begin
        awvalid <= 1'b0;
        wvalid <= 1'b1;
        beat <= '0;
      end else if (accept && (fill == LAST_BEAT)) begin
        awvalid <= 1'b1;
      end
      if (wvalid && wready) begin
        beat <= beat + 1'b1;
        if (wlast) begin
          wvalid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (accept) begin
      stage[fill] <= word_data.raw;
    end
  end

  a_bresp_okay: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    bvalid |-> (bresp == adcfifo_pkg::RESP_OKAY));

  // a new burst waits until the previous data phase is over
  a_aw_after_data: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    awvalid |-> !wvalid);

endmodule

// File: adcfifo_rd.sv
/* burst reader with credit gated read requests and read data forwarded to dma */
`timescale 1ns/1ps

module adcfifo_rd #(
  parameter int BURST_LEN = 4,
  parameter int MEM_WORDS = 64,
  localparam int AW = $clog2(MEM_WORDS)
) (
  input  logic                                 axi_clk,
  input  logic                                 axi_resetn,
  input  logic                                 xfer_init,
  input  logic                                 xfer_enable,
  input  logic                                 credit_ok,
  input  logic                                 arready,
  input  logic                                 rvalid,
  input  logic [adcfifo_pkg::DATA_WIDTH-1:0]   rdata,
  input  logic                                 rlast,
  input  logic [1:0]                           rresp,
  output logic                                 arvalid,
  output logic [AW-1:0]                        araddr,
  output logic                                 burst_take,
  output logic                                 rd_done,
  output logic                                 dma_valid,
  output logic [adcfifo_pkg::DATA_WIDTH-1:0]   dma_data
);

  // read pointer one bit wider so it can sit at the end of memory
  localparam logic [AW:0] ADDR_END = (AW + 1)'(MEM_WORDS);

  logic [AW:0] rd_addr;
  logic        active;
  logic        rd_start;

  // one burst in flight at a time and only with a burst of credit
  assign rd_start = xfer_enable && !xfer_init && !active && credit_ok &&
                    (rd_addr < ADDR_END);
  assign araddr = rd_addr[AW-1:0];
  assign rd_done = (rd_addr == ADDR_END) && !active;

  // ********************
  // read request

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      rd_addr <= '0;
      active <= 1'b0;
      arvalid <= 1'b0;
      burst_take <= 1'b0;
    end else begin
      // credit leaves together with the rising arvalid
      burst_take <= rd_start;
      if (rd_start) begin
        active <= 1'b1;
        arvalid <= 1'b1;
      end else if (arvalid && arready) begin
        arvalid <= 1'b0;
      end
      // burst stays active until its last beat is back
      if (rvalid && rlast) begin
        active <= 1'b0;
      end
      if (xfer_init) begin
        rd_addr <= '0;
      end else if (arvalid && arready) begin
        rd_addr <= rd_addr + (AW + 1)'(BURST_LEN);
      end
    end
  end

  // ********************
  // dma side

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      dma_valid <= 1'b0;
    end else begin
      dma_valid <= rvalid;
    end
  end

  always_ff @(posedge axi_clk) begin
    dma_data <= rdata;
  end

  // read data only comes back for the burst this reader opened
  a_r_in_burst: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    rvalid |-> active);

  a_rresp_okay: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    rvalid |-> (rresp == adcfifo_pkg::RESP_OKAY));

endmodule

// File: adcfifo_mem.sv
/* on-chip burst memory answering the write and read channels */
`timescale 1ns/1ps

module adcfifo_mem #(
  parameter int BURST_LEN = 4,
  parameter int MEM_WORDS = 64,
  localparam int AW = $clog2(MEM_WORDS)
) (
  input  logic                                 axi_clk,
  input  logic                                 axi_resetn,
  input  logic                                 awvalid,
  input  logic [AW-1:0]                        awaddr,
  input  logic                                 wvalid,
  input  logic [adcfifo_pkg::DATA_WIDTH-1:0]   wdata,
  input  logic                                 wlast,
  input  logic                                 arvalid,
  input  logic [AW-1:0]                        araddr,
  output logic                                 awready,
  output logic                                 wready,
  output logic                                 bvalid,
  output logic [1:0]                           bresp,
  output logic                                 arready,
  output logic                                 rvalid,
  output logic [adcfifo_pkg::DATA_WIDTH-1:0]   rdata,
  output logic                                 rlast,
  output logic [1:0]                           rresp
);

  localparam int BW = $clog2(BURST_LEN);
  localparam logic [BW-1:0] LAST_BEAT = BW'(BURST_LEN - 1);

  logic [adcfifo_pkg::DATA_WIDTH-1:0] mem [MEM_WORDS];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [BW-1:0] rd_beat;
  logic          rd_busy;

  // write side never stalls, and nothing here can fail
  assign awready = 1'b1;
  assign wready = 1'b1;
  assign bresp = adcfifo_pkg::RESP_OKAY;
  assign rresp = adcfifo_pkg::RESP_OKAY;

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      wr_ptr <= '0;
      bvalid <= 1'b0;
      arready <= 1'b0;
      rd_ptr <= '0;
      rd_beat <= '0;
      rd_busy <= 1'b0;
      rvalid <= 1'b0;
      rlast <= 1'b0;
    end else begin
      // ********************
      // write burst, incrementing
      if (awvalid && awready) begin
        wr_ptr <= awaddr;
      end else if (wvalid && wready) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      bvalid <= wvalid && wready && wlast;
      // ********************
      // read burst
      // one-cycle arready the cycle after arvalid
      arready <= arvalid && !arready && !rd_busy;
      if (arvalid && arready) begin
        rd_ptr <= araddr;
        rd_beat <= '0;
        rd_busy <= 1'b1;
      end else if (rd_busy) begin
        rd_ptr <= rd_ptr + 1'b1;
        rd_beat <= rd_beat + 1'b1;
        if (rd_beat == LAST_BEAT) begin
          rd_busy <= 1'b0;
        end
      end
      // beats leave one cycle behind the pointer
      rvalid <= rd_busy;
      rlast <= rd_busy && (rd_beat == LAST_BEAT);
    end
  end

  always_ff @(posedge axi_clk) begin
    if (wvalid && wready) begin
      mem[wr_ptr] <= wdata;
    end
    rdata <= mem[rd_ptr];
  end

endmodule

// File: adcfifo_top.sv
/* adc capture buffer top: parameters and wiring of sequencer, credit
   counter, packer, burst writer, burst reader and burst memory */
`timescale 1ns/1ps

module adcfifo_top #(
  parameter int BURST_LEN = 4,
  parameter int MEM_WORDS = 64,
  parameter int CREDIT_MAX = 16
) (
  input  logic                                 axi_clk,
  input  logic                                 axi_resetn,
  input  logic                                 capture_req,
  input  logic                                 adc_valid,
  input  logic [adcfifo_pkg::SAMPLE_WIDTH-1:0] adc_data,
  input  logic                                 dma_xfer_req,
  input  logic                                 dma_credit,
  output logic                                 capture_done,
  output logic                                 dma_valid,
  output logic [adcfifo_pkg::DATA_WIDTH-1:0]   dma_data
);

  localparam int AW = $clog2(MEM_WORDS);
  localparam int CNT_W = $clog2(MEM_WORDS + 1);

  // ********************
  // sequencing and credit
  logic             capture_en;
  logic             xfer_init;
  logic             xfer_enable;
  logic             flush_credits;
  logic             credit_ok;
  logic             burst_take;
  logic             rd_done;
  logic [CNT_W-1:0] wr_words;

  // packer to writer
  logic                   word_valid;
  adcfifo_pkg::axi_word_t word_data;

  // write channel
  logic                                awvalid;
  logic                                awready;
  logic [AW-1:0]                       awaddr;
  logic                                wvalid;
  logic                                wready;
  logic                                wlast;
  logic [adcfifo_pkg::DATA_WIDTH-1:0]  wdata;
  logic                                bvalid;
  logic [1:0]                          bresp;

  // read channel
  logic                                arvalid;
  logic                                arready;
  logic [AW-1:0]                       araddr;
  logic                                rvalid;
  logic                                rlast;
  logic [adcfifo_pkg::DATA_WIDTH-1:0]  rdata;
  logic [1:0]                          rresp;

  adcfifo_ctrl #(.MEM_WORDS(MEM_WORDS)) ctrl0 (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn),
    .capture_req(capture_req), .dma_xfer_req(dma_xfer_req),
    .wr_words(wr_words), .rd_done(rd_done),
    .capture_en(capture_en), .capture_done(capture_done),
    .xfer_init(xfer_init), .xfer_enable(xfer_enable),
    .flush_credits(flush_credits)
  );

  adcfifo_credit #(.BURST_LEN(BURST_LEN), .CREDIT_MAX(CREDIT_MAX)) credit0 (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn),
    .dma_credit(dma_credit), .burst_take(burst_take),
    .flush_credits(flush_credits), .credit_ok(credit_ok)
  );

  adcfifo_pack pack0 (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn),
    .capture_en(capture_en), .adc_valid(adc_valid), .adc_data(adc_data),
    .word_valid(word_valid), .word_data(word_data)
  );

  adcfifo_wr #(.BURST_LEN(BURST_LEN), .MEM_WORDS(MEM_WORDS)) wr0 (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn),
    .capture_en(capture_en), .xfer_init(xfer_init),
    .word_valid(word_valid), .word_data(word_data),
    .awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
    .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
    .wlast(wlast), .wr_words(wr_words)
  );

  adcfifo_rd #(.BURST_LEN(BURST_LEN), .MEM_WORDS(MEM_WORDS)) rd0 (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn),
    .xfer_init(xfer_init), .xfer_enable(xfer_enable), .credit_ok(credit_ok),
    .arready(arready), .rvalid(rvalid), .rdata(rdata), .rlast(rlast),
    .rresp(rresp), .arvalid(arvalid), .araddr(araddr),
    .burst_take(burst_take), .rd_done(rd_done),
    .dma_valid(dma_valid), .dma_data(dma_data)
  );

  adcfifo_mem #(.BURST_LEN(BURST_LEN), .MEM_WORDS(MEM_WORDS)) mem0 (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn),
    .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
    .wlast(wlast), .arvalid(arvalid), .araddr(araddr),
    .awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
    .arready(arready), .rvalid(rvalid), .rdata(rdata), .rlast(rlast),
    .rresp(rresp)
  );

endmodule

// File: tb_adcfifo.sv
/* testbench for the adc capture buffer: random sample capture,
   credit gated readback with data, credit and quiet window checks */
`timescale 1ns/1ps

module tb_adcfifo;

  localparam int BURST_LEN = 4;
  localparam int MEM_WORDS = 64;
  localparam int CREDIT_MAX = 16;
  localparam int SPW = adcfifo_pkg::SAMPLES_PER_WORD;

  logic axi_clk;
  logic axi_resetn;
  logic capture_req;
  logic adc_valid;
  logic [adcfifo_pkg::SAMPLE_WIDTH-1:0] adc_data;
  logic dma_xfer_req;
  logic dma_credit;
  logic capture_done;
  logic dma_valid;
  logic [adcfifo_pkg::DATA_WIDTH-1:0] dma_data;

  // reference model state
  integer seed;
  logic [adcfifo_pkg::SAMPLE_WIDTH-1:0] samples [$];
  int credits_total;
  int beats_total;
  int words_rx;
  logic reading;
  logic window;

  adcfifo_top #(
    .BURST_LEN(BURST_LEN),
    .MEM_WORDS(MEM_WORDS),
    .CREDIT_MAX(CREDIT_MAX)
  ) dut0 (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn),
    .capture_req(capture_req), .adc_valid(adc_valid), .adc_data(adc_data),
    .dma_xfer_req(dma_xfer_req), .dma_credit(dma_credit),
    .capture_done(capture_done), .dma_valid(dma_valid), .dma_data(dma_data)
  );

  initial begin
    axi_clk = 1'b0;
    forever #4 axi_clk = ~axi_clk;
  end

  // ********************
  // failure reporting

  task automatic report_value(string name, logic [63:0] expected, logic [63:0] actual);
    $display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1, "stopping on first error");
  endtask

  task automatic report_failure(string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "stopping on first error");
  endtask

  // one clock edge, dma side observed with the values the dut sampled
  task automatic next_cycle();
    adcfifo_pkg::axi_word_t w;
    int base;
    int j;
    @(posedge axi_clk);
    if (dma_valid) begin
      assert (!window) else
        report_failure("dma_valid appeared with fewer than BURST_LEN credits outstanding");
      assert (reading) else
        report_failure("dma_valid seen outside a readback or past the memory depth");
      // beat count must stay covered by credits already granted
      assert (beats_total < credits_total) else
        report_failure("more dma words delivered than credits granted");
      w.raw = dma_data;
      base = SPW * words_rx;
      // lane 0 carries the oldest sample of the word
      for (j = 0; j < SPW; j++) begin
        assert (w.lane[j] == samples[base + j]) else
          report_value($sformatf("dma_data word %0d lane %0d", words_rx, j),
                       64'(samples[base + j]), 64'(w.lane[j]));
      end
      words_rx++;
      beats_total++;
      if (words_rx == MEM_WORDS) begin
        reading = 1'b0;
      end
    end
    if (dma_credit) begin
      credits_total++;
    end
  endtask

  // ********************
  // capture

  task automatic run_capture();
    logic [adcfifo_pkg::SAMPLE_WIDTH-1:0] s;
    int n;
    int cycles;
    samples.delete();
    // the new capture flushes whatever credit the dut still holds
    credits_total = 0;
    beats_total = 0;
    capture_req <= 1'b1;
    repeat (3) next_cycle();
    n = 0;
    while (n < MEM_WORDS * SPW) begin
      assert (!capture_done) else
        report_failure("capture_done rose before all samples were accepted");
      if (($random(seed) & 3) != 0) begin
        s = 16'($random(seed));
        adc_valid <= 1'b1;
        adc_data <= s;
        samples.push_back(s);
        n++;
      end else begin
        adc_valid <= 1'b0;
      end
      next_cycle();
    end
    // adc keeps running, none of these samples may land in memory
    cycles = 0;
    while (!capture_done) begin
      adc_valid <= ($random(seed) & 1) != 0;
      adc_data <= 16'($random(seed));
      next_cycle();
      cycles++;
      if (cycles > 500) begin
        report_failure("timeout waiting for capture_done after the last sample");
      end
    end
    capture_req <= 1'b0;
    repeat (8) begin
      adc_valid <= 1'b1;
      adc_data <= 16'($random(seed));
      next_cycle();
    end
    adc_valid <= 1'b0;
    next_cycle();
  endtask

  // ********************
  // readback

  task automatic run_readback();
    int g;
    int gap;
    int cycles;
    int i;
    words_rx = 0;
    reading = 1'b1;
    dma_xfer_req <= 1'b1;
    while (words_rx < MEM_WORDS) begin
      // random grant, kept below the counter ceiling
      g = 1 + ($random(seed) & 7);
      if (credits_total - beats_total + g > CREDIT_MAX) begin
        g = CREDIT_MAX - (credits_total - beats_total);
      end
      for (i = 0; i < g; i++) begin
        dma_credit <= 1'b1;
        next_cycle();
        dma_credit <= 1'b0;
        gap = $random(seed) & 3;
        repeat (gap) next_cycle();
      end
      // settled once every burst in flight is back and under a burst of credit is left
      cycles = 0;
      while ((words_rx < MEM_WORDS) &&
             !((credits_total - beats_total < BURST_LEN) && (beats_total % BURST_LEN == 0))) begin
        next_cycle();
        cycles++;
        if (cycles > 300) begin
          report_failure("timeout waiting for read bursts to drain");
        end
      end
      if (words_rx < MEM_WORDS) begin
        window = 1'b1;
        repeat (100) next_cycle();
        window = 1'b0;
      end
    end
    dma_xfer_req <= 1'b0;
    // no word past the memory depth may follow
    repeat (20) next_cycle();
    assert (capture_done) else
      report_value("capture_done", 64'(1), 64'(capture_done));
  endtask

  // ********************
  // sequence

  initial begin
    seed = 32'h61b;
    axi_resetn = 1'b0;
    capture_req = 1'b0;
    adc_valid = 1'b0;
    adc_data = '0;
    dma_xfer_req = 1'b0;
    dma_credit = 1'b0;
    credits_total = 0;
    beats_total = 0;
    words_rx = 0;
    reading = 1'b0;
    window = 1'b0;
    repeat (4) @(posedge axi_clk);
    axi_resetn <= 1'b1;
    // idle, no request
    repeat (20) begin
      next_cycle();
      assert (!capture_done) else
        report_value("capture_done", 64'(0), 64'(capture_done));
    end
    run_capture();
    run_readback();
    // same capture read a second time
    run_readback();
    // fresh samples replace the memory contents
    run_capture();
    run_readback();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: files.f
adcfifo_pkg.sv
adcfifo_ctrl.sv
adcfifo_credit.sv
adcfifo_pack.sv
adcfifo_wr.sv
adcfifo_rd.sv
adcfifo_mem.sv
adcfifo_top.sv
tb_adcfifo.sv

// File: run.sh
#!/bin/sh
# compile and run the adc capture buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --top-module tb_adcfifo \
  -f files.f \
  -o tb_adcfifo
./obj_dir/tb_adcfifo
